// File: flist.f
src/pu_isa_pkg.sv
src/pu_pkt_pkg.sv
src/pu_decode.sv
src/pu_execute.sv
src/pu_result.sv
src/pu_top.sv
tests/tb_pu_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the packet unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_pu_top -f flist.f -o sim_pu
./obj_dir/sim_pu | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi

// File: tests/tb_pu_top.sv
// Testbench for the packet unit.
// Loads random programs, sends random packets and checks the egress stream
// against a reference model of the instruction set.

`timescale 1ns/100ps
`default_nettype none

module tb_pu_top;

    import pu_isa_pkg::*;
    import pu_pkt_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_wr;
    logic [PC_NBITS-1:0]   inst_waddr;
    logic [INST_NBITS-1:0] inst_wdata;
    logic                  pkt_valid;
    logic                  pkt_sop;
    logic                  pkt_eop;
    logic [DATA_NBITS-1:0] pkt_data;
    logic                  em_valid;
    logic                  em_sop;
    logic                  em_eop;
    logic [PORT_NBITS-1:0] em_port_id;
    logic [DATA_NBITS-1:0] em_data;
    logic                  pu_busy;

    logic [INST_NBITS-1:0] prog [PROG_DEPTH];
    logic [DATA_NBITS-1:0] words [PKT_DEPTH];
    logic [DATA_NBITS-1:0] exp_words [PKT_DEPTH];
    logic [PORT_NBITS-1:0] exp_port;
    int                    nwords;

    pu_top pu_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_wr    (inst_wr),
        .inst_waddr (inst_waddr),
        .inst_wdata (inst_wdata),
        .pkt_valid  (pkt_valid),
        .pkt_sop    (pkt_sop),
        .pkt_eop    (pkt_eop),
        .pkt_data   (pkt_data),
        .em_valid   (em_valid),
        .em_sop     (em_sop),
        .em_eop     (em_eop),
        .em_port_id (em_port_id),
        .em_data    (em_data),
        .pu_busy    (pu_busy)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    // Random program with the halt at halt_pos, or none when it is negative.
    task automatic make_program(input int halt_pos);
        logic [3:0] op;
        for (int a = 0; a < PROG_DEPTH; a++) begin
            op      = 4'($urandom_range(14, 0));   // Unused codes 7 to 14 included.
            prog[a] = {op, 12'($urandom())};
            if (a == halt_pos) begin
                prog[a][15:12] = OP_HALT;
            end
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < PROG_DEPTH; a++) begin
            inst_wr    = 1'b1;
            inst_waddr = PC_NBITS'(a);
            inst_wdata = prog[a];
            @(negedge clk);
        end
        inst_wr = 1'b0;
    endtask

    // Executes the program over the packet, word slots past the length start at zero.
    task automatic run_model();
        logic [DATA_NBITS-1:0] regs [REG_NUM];
        logic [3:0]            op;
        logic [1:0]            rd;
        logic [1:0]            rs;
        logic [7:0]            imm;
        for (int r = 0; r < REG_NUM; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < PKT_DEPTH; i++) begin
            exp_words[i] = (i < nwords) ? words[i] : '0;
        end
        exp_port = '0;
        for (int pc = 0; pc < PROG_DEPTH; pc++) begin
            {op, rd, rs, imm} = prog[pc];
            case (op)
                OP_LDW:  regs[rd] = exp_words[imm[2:0]];
                OP_STW:  exp_words[imm[2:0]] = regs[rs];
                OP_ADDI: regs[rd] = regs[rs] + {24'd0, imm};
                OP_XOR:  regs[rd] = regs[rd] ^ regs[rs];
                OP_SHL:  regs[rd] = regs[rs] << imm[4:0];
                OP_PORT: exp_port = imm[3:0];
                default: ;
            endcase
            if (op == OP_HALT) begin
                break;
            end
        end
    endtask

    task automatic send_packet();
        int gap;
        for (int i = 0; i < nwords; i++) begin
            gap       = $urandom_range(2, 0);  // Idle cycles before the word.
            pkt_valid = 1'b0;
            repeat (gap) @(negedge clk);
            pkt_valid = 1'b1;
            pkt_sop   = (i == 0);
            pkt_eop   = (i == nwords - 1);
            pkt_data  = words[i];
            @(negedge clk);
        end
        pkt_valid = 1'b0;
        pkt_sop   = 1'b0;
        pkt_eop   = 1'b0;
    endtask

    task automatic receive_and_check(input string name);
        int cycles;
        cycles = 0;
        while (em_sop !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (em_sop !== 1'b1) begin
            fail_run($sformatf("%s: no egress packet started within %0d cycles",
                               name, TIMEOUT_CYCLES));
        end
        for (int i = 0; i < nwords; i++) begin
            check($sformatf("%s valid %0d", name, i), 32'd1, 32'(em_valid));
            check($sformatf("%s sop %0d", name, i), 32'(i == 0), 32'(em_sop));
            check($sformatf("%s eop %0d", name, i), 32'(i == nwords - 1), 32'(em_eop));
            check($sformatf("%s port %0d", name, i), 32'(exp_port), 32'(em_port_id));
            check($sformatf("%s word %0d", name, i), exp_words[i], em_data);
            @(negedge clk);
        end
        check({name, " valid after eop"}, 32'd0, 32'(em_valid));
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while (pu_busy !== 1'b0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (pu_busy !== 1'b0) begin
            fail_run($sformatf("%s: unit still busy after %0d cycles",
                               name, TIMEOUT_CYCLES));
        end
    endtask

    // One packet through a freshly loaded program.
    task automatic run_case(input string name, input int halt_pos, input int len);
        make_program(halt_pos);
        load_program();
        nwords = len;
        for (int i = 0; i < len; i++) begin
            words[i] = $urandom();
        end
        run_model();
        send_packet();
        check({name, " busy"}, 32'd1, 32'(pu_busy));
        receive_and_check(name);
        wait_idle(name);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_wr    = 1'b0;
        inst_waddr = '0;
        inst_wdata = '0;
        pkt_valid  = 1'b0;
        pkt_sop    = 1'b0;
        pkt_eop    = 1'b0;
        pkt_data   = '0;
        nwords     = 0;
        void'($urandom(81));
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("reset em_valid", 32'd0, 32'(em_valid));
        check("reset pu_busy", 32'd0, 32'(pu_busy));

        for (int t = 0; t < 8; t++) begin
            run_case($sformatf("halt first %0d", t), 0, $urandom_range(8, 1));
        end
        for (int t = 0; t < 200; t++) begin
            run_case($sformatf("random %0d", t), $urandom_range(15, 0), $urandom_range(8, 1));
        end
        for (int t = 0; t < 20; t++) begin
            run_case($sformatf("no halt %0d", t), -1, $urandom_range(8, 1));
        end
        for (int n = 1; n <= PKT_DEPTH; n++) begin
            run_case($sformatf("length %0d", n), $urandom_range(15, 0), n);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/pu_top.sv
// Packet unit with one programmable core.
// Connects the decode, execute and result stages.

`timescale 1ns/100ps
`default_nettype none

module pu_top (
    input  wire                                   clk,
    input  wire                                   rst_n,

    input  wire                                   inst_wr,
    input  wire  [pu_isa_pkg::PC_NBITS-1:0]       inst_waddr,
    input  wire  [pu_isa_pkg::INST_NBITS-1:0]     inst_wdata,

    input  wire                                   pkt_valid,
    input  wire                                   pkt_sop,
    input  wire                                   pkt_eop,
    input  wire  [pu_pkt_pkg::DATA_NBITS-1:0]     pkt_data,

    output logic                                  em_valid,
    output logic                                  em_sop,
    output logic                                  em_eop,
    output logic [pu_pkt_pkg::PORT_NBITS-1:0]     em_port_id,
    output logic [pu_pkt_pkg::DATA_NBITS-1:0]     em_data,

    output logic                                  pu_busy
);

    import pu_isa_pkg::*;
    import pu_pkt_pkg::*;

    logic                      run_start;
    logic                      run_done;
    logic                      issue;
    pu_opcode_e                op;
    logic [REG_SEL_NBITS-1:0]  rd_sel;
    logic [REG_SEL_NBITS-1:0]  rs_sel;
    logic [IMM_NBITS-1:0]      imm;
    logic [WORD_IDX_NBITS-1:0] buf_rd_idx;
    logic [DATA_NBITS-1:0]     buf_rd_data;
    logic                      buf_wr;
    logic [WORD_IDX_NBITS-1:0] buf_wr_idx;
    logic [DATA_NBITS-1:0]     buf_wr_data;
    logic [PORT_NBITS-1:0]     port_id;

    pu_decode u_pu_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_wr    (inst_wr),
        .inst_waddr (inst_waddr),
        .inst_wdata (inst_wdata),
        .run_start  (run_start),
        .issue      (issue),
        .op         (op),
        .rd_sel     (rd_sel),
        .rs_sel     (rs_sel),
        .imm        (imm),
        .run_done   (run_done)
    );

    pu_execute u_pu_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .run_start   (run_start),
        .issue       (issue),
        .op          (op),
        .rd_sel      (rd_sel),
        .rs_sel      (rs_sel),
        .imm         (imm),
        .buf_rd_idx  (buf_rd_idx),
        .buf_rd_data (buf_rd_data),
        .buf_wr      (buf_wr),
        .buf_wr_idx  (buf_wr_idx),
        .buf_wr_data (buf_wr_data),
        .port_id     (port_id)
    );

    pu_result u_pu_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .pkt_valid   (pkt_valid),
        .pkt_sop     (pkt_sop),
        .pkt_eop     (pkt_eop),
        .pkt_data    (pkt_data),
        .run_done    (run_done),
        .buf_rd_idx  (buf_rd_idx),
        .buf_rd_data (buf_rd_data),
        .buf_wr      (buf_wr),
        .buf_wr_idx  (buf_wr_idx),
        .buf_wr_data (buf_wr_data),
        .port_id     (port_id),
        .run_start   (run_start),
        .pu_busy     (pu_busy),
        .em_valid    (em_valid),
        .em_sop      (em_sop),
        .em_eop      (em_eop),
        .em_port_id  (em_port_id),
        .em_data     (em_data)
    );

endmodule

`default_nettype wire

// File: src/pu_result.sv
// Result stage of the packet unit.
// Owns the packet buffer and the receive, run and send sequencing.
// Words are taken on a valid/sop/eop stream and sent out after the program halts.

`timescale 1ns/100ps
`default_nettype none

module pu_result (
    input  wire                                    clk,
    input  wire                                    rst_n,

    input  wire                                    pkt_valid,
    input  wire                                    pkt_sop,
    input  wire                                    pkt_eop,
    input  wire  [pu_pkt_pkg::DATA_NBITS-1:0]      pkt_data,

    input  wire                                    run_done,

    input  wire  [pu_pkt_pkg::WORD_IDX_NBITS-1:0]  buf_rd_idx,
    output logic [pu_pkt_pkg::DATA_NBITS-1:0]      buf_rd_data,
    input  wire                                    buf_wr,
    input  wire  [pu_pkt_pkg::WORD_IDX_NBITS-1:0]  buf_wr_idx,
    input  wire  [pu_pkt_pkg::DATA_NBITS-1:0]      buf_wr_data,
    input  wire  [pu_pkt_pkg::PORT_NBITS-1:0]      port_id,

    output logic                                   run_start,
    output logic                                   pu_busy,

    output logic                                   em_valid,
    output logic                                   em_sop,
    output logic                                   em_eop,
    output logic [pu_pkt_pkg::PORT_NBITS-1:0]      em_port_id,
    output logic [pu_pkt_pkg::DATA_NBITS-1:0]      em_data
);

    import pu_pkt_pkg::*;

    pu_state_e                 state;
    logic [DATA_NBITS-1:0]     pkt_buf [PKT_DEPTH];
    logic [LEN_NBITS-1:0]      len;
    logic [WORD_IDX_NBITS-1:0] send_idx;
    logic                      len_full;
    logic                      rx_open;
    logic                      sop_take;
    logic                      word_take;
    logic                      eop_take;
    logic                      em_last;

    assign rx_open   = (state == ST_IDLE) || (state == ST_RECV);
    assign sop_take  = pkt_valid && pkt_sop && rx_open;
    assign word_take = pkt_valid && !pkt_sop && (state == ST_RECV);
    assign eop_take  = (sop_take || word_take) && pkt_eop;
    assign len_full  = (len == LEN_NBITS'(PKT_DEPTH));         // Later words are dropped.

    // A new packet starts from an all-zero buffer.
    always_ff @(posedge clk) begin
        if (sop_take) begin
            for (int i = 0; i < PKT_DEPTH; i++) begin
                pkt_buf[i] <= '0;
            end
            pkt_buf[0] <= pkt_data;
        end else if (word_take && !len_full) begin
            pkt_buf[len[WORD_IDX_NBITS-1:0]] <= pkt_data;
        end else if (buf_wr) begin
            pkt_buf[buf_wr_idx] <= buf_wr_data;
        end
    end

    assign buf_rd_data = pkt_buf[buf_rd_idx];

    assign em_last = ((LEN_NBITS'(send_idx) + LEN_NBITS'(1)) == len);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            run_start <= 1'b0;
            len       <= '0;
            send_idx  <= '0;
        end else begin
            run_start <= eop_take;                              // One cycle after eop.
            if (sop_take) begin
                len <= LEN_NBITS'(1);
            end else if (word_take && !len_full) begin
                len <= len + LEN_NBITS'(1);
            end
            case (state)
                ST_IDLE, ST_RECV: begin
                    if (eop_take) begin
                        state <= ST_RUN;
                    end else if (sop_take) begin
                        state <= ST_RECV;
                    end
                end
                ST_RUN: begin
                    if (run_done) begin
                        state    <= ST_SEND;
                        send_idx <= '0;
                    end
                end
                ST_SEND: begin
                    send_idx <= send_idx + WORD_IDX_NBITS'(1);
                    if (em_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign pu_busy = (state != ST_IDLE);

    // Egress, one word per cycle with no back-pressure.
    assign em_valid   = (state == ST_SEND);
    assign em_sop     = em_valid && (send_idx == '0);
    assign em_eop     = em_valid && em_last;
    assign em_data    = pkt_buf[send_idx];
    assign em_port_id = port_id;                                // Held by execute until next run.

    a_no_input_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == ST_RUN || state == ST_SEND) |-> !pkt_valid
    ) else $error("packet input while the unit is busy");

    a_done_only_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        run_done |-> state == ST_RUN
    ) else $error("run_done outside of a run");

endmodule

`default_nettype wire

// File: src/pu_execute.sv
// Execute stage of the packet unit core.
// Four 32-bit registers, the operation unit and the egress port register.
// Packet words are read and written through the result stage's buffer ports.

`timescale 1ns/100ps
`default_nettype none

module pu_execute (
    input  wire                                    clk,
    input  wire                                    rst_n,

    input  wire                                    run_start,
    input  wire                                    issue,
    input  wire pu_isa_pkg::pu_opcode_e            op,
    input  wire [pu_isa_pkg::REG_SEL_NBITS-1:0]    rd_sel,
    input  wire [pu_isa_pkg::REG_SEL_NBITS-1:0]    rs_sel,
    input  wire [pu_isa_pkg::IMM_NBITS-1:0]        imm,

    output logic [pu_pkt_pkg::WORD_IDX_NBITS-1:0]  buf_rd_idx,
    input  wire  [pu_pkt_pkg::DATA_NBITS-1:0]      buf_rd_data,
    output logic                                   buf_wr,
    output logic [pu_pkt_pkg::WORD_IDX_NBITS-1:0]  buf_wr_idx,
    output logic [pu_pkt_pkg::DATA_NBITS-1:0]      buf_wr_data,

    output logic [pu_pkt_pkg::PORT_NBITS-1:0]      port_id
);

    import pu_isa_pkg::*;
    import pu_pkt_pkg::*;

    logic [DATA_NBITS-1:0] regs [REG_NUM];
    logic [DATA_NBITS-1:0] rd_val;
    logic [DATA_NBITS-1:0] rs_val;
    logic                  reg_wr;
    logic [DATA_NBITS-1:0] reg_wdata;
    logic [PORT_NBITS-1:0] port_r;

    assign rd_val = regs[rd_sel];
    assign rs_val = regs[rs_sel];

    // Packet word index comes from the low imm bits for both LDW and STW.
    assign buf_rd_idx  = imm[WORD_IDX_NBITS-1:0];
    assign buf_wr_idx  = imm[WORD_IDX_NBITS-1:0];
    assign buf_wr_data = rs_val;
    assign buf_wr      = issue && (op == OP_STW);

    always_comb begin
        reg_wr    = 1'b0;
        reg_wdata = rs_val;
        if (issue) begin
            case (op)
                OP_LDW: begin
                    reg_wr    = 1'b1;
                    reg_wdata = buf_rd_data;
                end
                OP_ADDI: begin
                    reg_wr    = 1'b1;
                    reg_wdata = rs_val + DATA_NBITS'(imm);  // Wraps modulo 2^32.
                end
                OP_XOR: begin
                    reg_wr    = 1'b1;
                    reg_wdata = rd_val ^ rs_val;
                end
                OP_SHL: begin
                    reg_wr    = 1'b1;
                    reg_wdata = rs_val << imm[SHAMT_NBITS-1:0];
                end
                default: begin
                    reg_wr = 1'b0;                          // NOP, STW, PORT, HALT, unused.
                end
            endcase
        end
    end

    // Each run starts from clean registers.
    always_ff @(posedge clk) begin
        if (run_start) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr) begin
            regs[rd_sel] <= reg_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_r <= '0;
        end else if (run_start) begin
            port_r <= '0;
        end else if (issue && op == OP_PORT) begin
            port_r <= imm[PORT_NBITS-1:0];
        end
    end

    assign port_id = port_r;

    // Decode must not issue in the cycle the result stage restarts the run.
    a_no_issue_at_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue |-> !run_start
    ) else $error("instruction issued in the cycle a run starts");

endmodule

`default_nettype wire

// File: src/pu_decode.sv
// Decode stage of the packet unit core.
// Holds the instruction memory and the program counter, issues one
// instruction per cycle from run_start until a halt or address 15.

`timescale 1ns/100ps
`default_nettype none

module pu_decode (
    input  wire                                   clk,
    input  wire                                   rst_n,

    input  wire                                   inst_wr,
    input  wire [pu_isa_pkg::PC_NBITS-1:0]        inst_waddr,
    input  wire [pu_isa_pkg::INST_NBITS-1:0]      inst_wdata,

    input  wire                                   run_start,

    output logic                                  issue,
    output pu_isa_pkg::pu_opcode_e                op,
    output logic [pu_isa_pkg::REG_SEL_NBITS-1:0]  rd_sel,
    output logic [pu_isa_pkg::REG_SEL_NBITS-1:0]  rs_sel,
    output logic [pu_isa_pkg::IMM_NBITS-1:0]      imm,
    output logic                                  run_done
);

    import pu_isa_pkg::*;

    logic [INST_NBITS-1:0] imem [PROG_DEPTH];
    logic [INST_NBITS-1:0] inst;
    logic [PC_NBITS-1:0]   pc;
    logic                  running;
    logic                  last_addr;

    // Host program load.
    always_ff @(posedge clk) begin
        if (inst_wr) begin
            imem[inst_waddr] <= inst_wdata;
        end
    end

    assign inst      = imem[pc];
    assign last_addr = (pc == PC_NBITS'(PROG_DEPTH - 1));

    assign issue  = running;
    assign op     = pu_opcode_e'(inst[OP_MSB:OP_LSB]);  // Unused codes pass as is.
    assign rd_sel = inst[RD_MSB:RD_LSB];
    assign rs_sel = inst[RS_MSB:RS_LSB];
    assign imm    = inst[IMM_MSB:IMM_LSB];

    // The halt itself still issues, as a no-op.
    assign run_done = running && (op == OP_HALT || last_addr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            pc      <= '0;
        end else if (run_start) begin
            running <= 1'b1;
            pc      <= '0;
        end else if (run_done) begin
            running <= 1'b0;
        end else if (running) begin
            pc <= pc + PC_NBITS'(1);
        end
    end

    // The program may not change under a running core.
    a_no_load_while_running: assert property (
        @(posedge clk) disable iff (!rst_n)
        running |-> !inst_wr
    ) else $error("instruction write while the program runs");

endmodule

`default_nettype wire

// File: src/pu_pkt_pkg.sv
// Packet side definitions of the packet unit.
// Word width, buffer depth, egress port id width and the unit's states.

`default_nettype none

package pu_pkt_pkg;

    localparam int DATA_NBITS     = 32;
    localparam int PKT_DEPTH      = 8;
    localparam int WORD_IDX_NBITS = 3;
    localparam int LEN_NBITS      = 4;    // Counts 0 to 8 words.
    localparam int PORT_NBITS     = 4;

    // Receive, run the program, send.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RECV,
        ST_RUN,
        ST_SEND
    } pu_state_e;

endpackage

`default_nettype wire

// File: src/pu_isa_pkg.sv
// Instruction set of the packet unit core.
// A 16-bit instruction holds a 4-bit opcode, two register selects
// and an 8-bit immediate.

`default_nettype none

package pu_isa_pkg;

    localparam int INST_NBITS    = 16;
    localparam int PROG_DEPTH    = 16;
    localparam int PC_NBITS      = 4;
    localparam int REG_NUM       = 4;
    localparam int REG_SEL_NBITS = 2;
    localparam int IMM_NBITS     = 8;
    localparam int SHAMT_NBITS   = 5;     // Shift amount in the low imm bits.

    localparam int OP_MSB  = 15;
    localparam int OP_LSB  = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 10;
    localparam int RS_MSB  = 9;
    localparam int RS_LSB  = 8;
    localparam int IMM_MSB = 7;
    localparam int IMM_LSB = 0;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDW  = 4'd1,                   // rd = pkt[imm].
        OP_STW  = 4'd2,                   // pkt[imm] = rs.
        OP_ADDI = 4'd3,
        OP_XOR  = 4'd4,
        OP_SHL  = 4'd5,
        OP_PORT = 4'd6,                   // Egress port = imm.
        OP_HALT = 4'd15
    } pu_opcode_e;

endpackage

`default_nettype wire
